/* hdl/cpu_consts.svh */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// one instruction byte per opcode or operand
`define INS_WIDTH 8

// data word and register width
`define DATA_WIDTH 12

// both memories share the address width
`define ADDR_WIDTH 8
`define MEM_DEPTH 256

`endif

/* hdl/cpuPkg.sv */
`include "cpu_consts.svh"

package cpuPkg;

    typedef enum logic [`INS_WIDTH-1:0] {
        NOP      = 8'h00,
        ENDOP    = 8'h01,
        CLAC     = 8'h02,
        LDIAC    = 8'h03,
        LDAC     = 8'h04,
        STR      = 8'h05,
        STIR     = 8'h06,
        JUMP     = 8'h07,
        JMPNZ    = 8'h08,
        JMPZ     = 8'h09,
        MUL      = 8'h0A,
        ADD      = 8'h0B,
        SUB      = 8'h0C,
        INCAC    = 8'h0D,
        MV_RL_AC = 8'h1F, // move group keeps the low nibble at 4'hF
        MV_RP_AC = 8'h2F,
        MV_RQ_AC = 8'h3F,
        MV_RC_AC = 8'h4F,
        MV_R_AC  = 8'h5F,
        MV_R1_AC = 8'h6F,
        MV_AC_RP = 8'h7F,
        MV_AC_RQ = 8'h8F,
        MV_AC_RL = 8'h9F
    } opcodeT;

    typedef enum logic [5:0] {
        IDLE, FETCH1, FETCH2, NOP1, ENDOP1, CLAC1,
        LDIAC1, LDIAC2, LDIAC3, LDIAC4, LDAC1, LDAC2, LDAC3,
        STR1, STR2, STIR1, STIR2, STIR3, JUMP1, JUMP2, SKIP1,
        MUL1, ADD1, SUB1, INCAC1,
        MV_RL_AC1, MV_RP_AC1, MV_RQ_AC1, MV_RC_AC1, MV_R_AC1, MV_R1_AC1,
        MV_AC_RP1, MV_AC_RQ1, MV_AC_RL1
    } stateT;

    typedef enum logic [2:0] {
        ALU_CLR, ALU_PASS, ALU_ADD, ALU_SUB, ALU_MUL, ALU_INC, ALU_IDLE
    } aluOpT;

    typedef enum logic [3:0] {
        BUS_DMEM, BUS_R, BUS_IR, BUS_RL, BUS_RC, BUS_RP, BUS_RQ, BUS_R1, BUS_AC, BUS_NONE
    } busSelT;

    typedef struct packed {
        logic ar;
        logic r;
        logic pc;
        logic ir;
        logic rl;
        logic rc;
        logic rp;
        logic rq;
        logic r1;
        logic ac;
    } regWrT;

    typedef struct packed {
        logic pc;
        logic rc;
        logic rp;
        logic rq;
    } regIncT;

    typedef struct packed {
        aluOpT  aluOp;
        regWrT  wr;
        regIncT inc;
        busSelT busSel;
        logic   dmemWe;
        logic   zWe;
    } ctrlWordT;

    typedef logic [`DATA_WIDTH-1:0] dataWordT;

    typedef struct packed {
        logic                   imemWe;
        logic                   dmemWe;
        logic [`ADDR_WIDTH-1:0] addr;
        dataWordT               data; // imem keeps the low byte only
    } hostReqT;

endpackage

/* hdl/controlUnit.sv */
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  logic     zero,
    input  opcodeT   ins,
    output ctrlWordT ctrl,
    output logic     ready,
    output logic     done
);

    stateT state;
    stateT nextState;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        ctrl        = '0;
        ctrl.aluOp  = ALU_IDLE;
        ctrl.busSel = BUS_NONE;
        nextState   = FETCH1; // most states end by fetching again
        case (state)
            IDLE:   nextState = start ? FETCH1 : IDLE;
            FETCH1: nextState = FETCH2; // imem reads PC
            FETCH2: begin
                ctrl.wr.ir  = 1'b1;
                ctrl.inc.pc = 1'b1;
                case (ins)
                    NOP:      nextState = NOP1;
                    ENDOP:    nextState = ENDOP1;
                    CLAC:     nextState = CLAC1;
                    LDIAC:    nextState = LDIAC1;
                    LDAC:     nextState = LDAC1;
                    STR:      nextState = STR1;
                    STIR:     nextState = STIR1;
                    JUMP:     nextState = JUMP1;
                    JMPNZ:    nextState = zero ? SKIP1 : JUMP1;
                    JMPZ:     nextState = zero ? JUMP1 : SKIP1;
                    MUL:      nextState = MUL1;
                    ADD:      nextState = ADD1;
                    SUB:      nextState = SUB1;
                    INCAC:    nextState = INCAC1;
                    MV_RL_AC: nextState = MV_RL_AC1;
                    MV_RP_AC: nextState = MV_RP_AC1;
                    MV_RQ_AC: nextState = MV_RQ_AC1;
                    MV_RC_AC: nextState = MV_RC_AC1;
                    MV_R_AC:  nextState = MV_R_AC1;
                    MV_R1_AC: nextState = MV_R1_AC1;
                    MV_AC_RP: nextState = MV_AC_RP1;
                    MV_AC_RQ: nextState = MV_AC_RQ1;
                    MV_AC_RL: nextState = MV_AC_RL1;
                    default:  nextState = IDLE;
                endcase
            end
            ENDOP1: nextState = ENDOP1; // parked until reset
            LDIAC1: nextState = LDIAC2; // operand byte on its way
            STIR1:  nextState = STIR2;
            JUMP1:  nextState = JUMP2;
            LDIAC2, STIR2: begin
                ctrl.busSel = BUS_IR;
                ctrl.wr.ir  = 1'b1;
                ctrl.wr.ar  = 1'b1;
                ctrl.inc.pc = 1'b1;
                nextState   = (state == LDIAC2) ? LDIAC3 : STIR3;
            end
            LDIAC3: nextState = LDIAC4; // dmem reads AR
            LDAC2:  nextState = LDAC3;
            LDAC1, STR1: begin
                ctrl.busSel = BUS_AC;
                ctrl.wr.ar  = 1'b1;
                nextState   = (state == LDAC1) ? LDAC2 : STR2;
            end
            LDIAC4, LDAC3: begin
                ctrl.busSel = BUS_DMEM;
                ctrl.aluOp  = ALU_PASS;
                ctrl.wr.ac  = 1'b1;
                ctrl.zWe    = 1'b1;
            end
            STR2: begin
                ctrl.busSel = BUS_R;
                ctrl.dmemWe = 1'b1;
            end
            STIR3: begin
                ctrl.busSel = BUS_AC;
                ctrl.dmemWe = 1'b1;
            end
            JUMP2: begin
                ctrl.busSel = BUS_IR;
                ctrl.wr.ir  = 1'b1;
                ctrl.wr.pc  = 1'b1;
            end
            SKIP1: ctrl.inc.pc = 1'b1; // step over the unused target byte
            CLAC1, ADD1, SUB1, MUL1, INCAC1: begin
                ctrl.wr.ac  = 1'b1;
                ctrl.zWe    = 1'b1;
                ctrl.aluOp  = (state == CLAC1) ? ALU_CLR :
                              (state == ADD1)  ? ALU_ADD :
                              (state == SUB1)  ? ALU_SUB :
                              (state == MUL1)  ? ALU_MUL : ALU_INC;
                ctrl.busSel = (state == ADD1) ? BUS_R :
                              (state == SUB1) ? BUS_RC :
                              (state == MUL1) ? BUS_R1 : BUS_NONE;
                ctrl.inc.rc = (state == MUL1);
                ctrl.inc.rp = (state == MUL1);
                ctrl.inc.rq = (state == MUL1);
            end
            MV_RL_AC1, MV_RP_AC1, MV_RQ_AC1, MV_RC_AC1, MV_R_AC1, MV_R1_AC1: begin
                ctrl.busSel = BUS_AC;
                ctrl.wr.rl  = (state == MV_RL_AC1);
                ctrl.wr.rp  = (state == MV_RP_AC1);
                ctrl.wr.rq  = (state == MV_RQ_AC1);
                ctrl.wr.rc  = (state == MV_RC_AC1);
                ctrl.wr.r   = (state == MV_R_AC1);
                ctrl.wr.r1  = (state == MV_R1_AC1);
            end
            MV_AC_RP1, MV_AC_RQ1, MV_AC_RL1: begin
                ctrl.aluOp  = ALU_PASS;
                ctrl.wr.ac  = 1'b1;
                ctrl.zWe    = 1'b1;
                ctrl.busSel = (state == MV_AC_RP1) ? BUS_RP :
                              (state == MV_AC_RQ1) ? BUS_RQ : BUS_RL;
            end
            NOP1:    nextState = FETCH1;
            default: nextState = IDLE;
        endcase
    end

    assign ready = (state == IDLE);
    assign done  = (state == ENDOP1);

endmodule

/* hdl/dataPath.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module dataPath import cpuPkg::*; (
    input  logic                   clk,
    input  logic                   reset,
    input  ctrlWordT               ctrl,
    input  logic [`INS_WIDTH-1:0]  ins,
    input  dataWordT               dmemRdata,
    output logic [`ADDR_WIDTH-1:0] pc,
    output logic [`ADDR_WIDTH-1:0] ar,
    output dataWordT               dmemWdata,
    output logic                   zero
);

    logic [`INS_WIDTH-1:0] ir;
    logic [`INS_WIDTH-1:0] irNext;
    dataWordT r, rl, rc, rp, rq, r1, ac;
    dataWordT bus;
    dataWordT aluOut;

    // IR is write-through, so an operand byte reaches the bus in the cycle it loads
    assign irNext = ctrl.wr.ir ? ins : ir;

    always_comb begin
        case (ctrl.busSel)
            BUS_DMEM: bus = dmemRdata;
            BUS_R:    bus = r;
            BUS_IR:   bus = dataWordT'(irNext);
            BUS_RL:   bus = rl;
            BUS_RC:   bus = rc;
            BUS_RP:   bus = rp;
            BUS_RQ:   bus = rq;
            BUS_R1:   bus = r1;
            BUS_AC:   bus = ac;
            default:  bus = '0;
        endcase
    end

    always_comb begin
        case (ctrl.aluOp)
            ALU_CLR:  aluOut = '0;
            ALU_PASS: aluOut = bus;
            ALU_ADD:  aluOut = ac + bus;
            ALU_SUB:  aluOut = ac - bus;
            ALU_MUL:  aluOut = ac * bus; // low 12 bits of the product
            ALU_INC:  aluOut = ac + 1'b1;
            default:  aluOut = ac;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ar   <= '0;
            r    <= '0;
            pc   <= '0;
            ir   <= '0;
            rl   <= '0;
            rc   <= '0;
            rp   <= '0;
            rq   <= '0;
            r1   <= '0;
            ac   <= '0;
            zero <= 1'b0;
        end else begin
            ir <= irNext;
            if (ctrl.wr.ar) ar <= bus[`ADDR_WIDTH-1:0];
            if (ctrl.wr.r)  r  <= bus;
            if (ctrl.wr.rl) rl <= bus;
            if (ctrl.wr.r1) r1 <= bus;
            if (ctrl.wr.ac) ac <= aluOut;
            if (ctrl.zWe)   zero <= (aluOut == '0);
            if (ctrl.wr.pc) begin
                pc <= bus[`ADDR_WIDTH-1:0];
            end else if (ctrl.inc.pc) begin
                pc <= pc + 1'b1;
            end
            if (ctrl.wr.rc) begin
                rc <= bus;
            end else if (ctrl.inc.rc) begin
                rc <= rc + 1'b1;
            end
            if (ctrl.wr.rp) begin
                rp <= bus;
            end else if (ctrl.inc.rp) begin
                rp <= rp + 1'b1;
            end
            if (ctrl.wr.rq) begin
                rq <= bus;
            end else if (ctrl.inc.rq) begin
                rq <= rq + 1'b1;
            end
        end
    end

    assign dmemWdata = bus; // stores take R or AC off the shared bus

endmodule

/* hdl/dualPortRam.sv */
`timescale 1ns/1ps

module dualPortRam #(
    parameter int WIDTH = 12,
    parameter int DEPTH = 256
) (
    input  logic                     clk,
    input  logic                     weA,
    input  logic [$clog2(DEPTH)-1:0] addrA,
    input  logic [WIDTH-1:0]         wdataA,
    output logic [WIDTH-1:0]         rdataA,
    input  logic                     weB,
    input  logic [$clog2(DEPTH)-1:0] addrB,
    input  logic [WIDTH-1:0]         wdataB,
    output logic [WIDTH-1:0]         rdataB
);

    localparam int addrWidth = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [2**addrWidth];

    always_ff @(posedge clk) begin
        if (weA) begin
            mem[addrA] <= wdataA;
        end
        if (weB) begin
            mem[addrB] <= wdataB; // port B wins a same-address collision
        end
        rdataA <= mem[addrA]; // read-before-write
        rdataB <= mem[addrB];
    end

endmodule

/* hdl/processorTop.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module processorTop import cpuPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     start,
    input  hostReqT  host,
    output dataWordT hostRdata,
    output logic     ready,
    output logic     done
);

    ctrlWordT               ctrl;
    logic                   zero;
    logic [`INS_WIDTH-1:0]  ins;
    logic [`ADDR_WIDTH-1:0] pc;
    logic [`ADDR_WIDTH-1:0] ar;
    dataWordT               dmemRdata;
    dataWordT               dmemWdata;

    controlUnit sequencer (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .zero  (zero),
        .ins   (opcodeT'(ins)),
        .ctrl  (ctrl),
        .ready (ready),
        .done  (done)
    );

    dataPath dp (
        .clk       (clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .ins       (ins),
        .dmemRdata (dmemRdata),
        .pc        (pc),
        .ar        (ar),
        .dmemWdata (dmemWdata),
        .zero      (zero)
    );

    // program store with port A read-only for the processor
    dualPortRam #(.WIDTH(`INS_WIDTH), .DEPTH(`MEM_DEPTH)) imem (
        .clk    (clk),
        .weA    (1'b0),
        .addrA  (pc),
        .wdataA ('0),
        .rdataA (ins),
        .weB    (host.imemWe),
        .addrB  (host.addr),
        .wdataB (host.data[`INS_WIDTH-1:0]),
        .rdataB ()
    );

    dualPortRam #(.WIDTH(`DATA_WIDTH), .DEPTH(`MEM_DEPTH)) dmem (
        .clk    (clk),
        .weA    (ctrl.dmemWe),
        .addrA  (ar),
        .wdataA (dmemWdata),
        .rdataA (dmemRdata),
        .weB    (host.dmemWe),
        .addrB  (host.addr),
        .wdataB (host.data),
        .rdataB (hostRdata)
    );

endmodule

/* sim/processor_assert.sv */
`timescale 1ns/1ps

module processorAssert import cpuPkg::*; (
    input logic     clk,
    input logic     reset,
    input logic     start,
    input logic     ready,
    input logic     done,
    input ctrlWordT ctrl
);

    // a finished program stays parked until reset
    doneHeld: assert property (@(posedge clk) disable iff (reset) done |=> done)
        else $error("done fell before reset");

    startAccepted: assert property (@(posedge clk) disable iff (reset)
        start && ready |=> !ready)
        else $error("ready still high one cycle after start");

    noStoreWhileHostOwns: assert property (@(posedge clk) disable iff (reset)
        (ready || done) |-> !ctrl.dmemWe)  // host owns dmem here
        else $error("data memory write while the host owns it");

endmodule

bind controlUnit processorAssert handshakeChecks (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .ready (ready),
    .done  (done),
    .ctrl  (ctrl)
);

/* sim/processorTb.sv */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module processorTb import cpuPkg::*; ();

    localparam int numRows     = 13;
    localparam int resetCycles = 16;
    localparam int doneTimeout = 500;

    typedef struct packed {
        opcodeT                 op;
        dataWordT               a;
        dataWordT               b;
        logic                   useRand;  // operands drawn from $random
        logic [`ADDR_WIDTH-1:0] expAddr;
        dataWordT               expValue;
    } testRowT;

    logic     clk;
    logic     reset;
    logic     start;
    hostReqT  host;
    dataWordT hostRdata;
    logic     ready;
    logic     done;

    testRowT               testTable [numRows];
    logic [`INS_WIDTH-1:0] prog [`MEM_DEPTH];
    dataWordT              image [`MEM_DEPTH];
    integer                seed;

    processorTop UUT (
        .clk       (clk),
        .reset     (reset),
        .start     (start),
        .host      (host),
        .hostRdata (hostRdata),
        .ready     (ready),
        .done      (done)
    );

    always #10 clk = ~clk;

    task automatic stepCycle();
        @(posedge clk);
        #2;
    endtask

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic checkWord(input string what, input dataWordT got, input dataWordT exp);
        if (got !== exp) begin
            abortRun($sformatf("Error at time %0t: %s read %03h, expected %03h",
                               $time, what, got, exp));
        end
    endtask

    task automatic checkFlags(input string what, input logic expReady, input logic expDone);
        if (ready !== expReady || done !== expDone) begin
            abortRun($sformatf("Error at time %0t: %s ready=%b done=%b, expected %b %b",
                               $time, what, ready, done, expReady, expDone));
        end
    endtask

    function automatic dataWordT expectedValue(input opcodeT op, input dataWordT a,
                                               input dataWordT b);
        case (op)
            ADD:      return b + a;
            SUB:      return b - a;
            MUL:      return b * a;  // low 12 bits of the product
            MV_AC_RP: return a + 12'd3;
            MV_AC_RL: return a + 12'd1;
            default:  return b;  // marker 2 for the jumps and b for LDAC and STR
        endcase
    endfunction

    task automatic setRow(input int idx, input opcodeT op, input dataWordT a,
                          input dataWordT b, input logic useRand);
        testRowT row;
        row.op      = op;
        row.useRand = useRand;
        row.a       = row.useRand ? dataWordT'($random(seed) & 32'hFFF) : a;
        row.b       = row.useRand ? dataWordT'($random(seed) & 32'hFFF) : b;
        if (op == LDAC || op == STR) begin
            row.a = row.a | 12'h010;  // pointer stays clear of dmem[0..2]
        end
        if (op == JMPZ || op == JMPNZ) begin
            row.b = ~row.a;  // second marker always differs
        end
        row.expAddr    = (op == STR) ? row.a[`ADDR_WIDTH-1:0] : 8'd2;
        row.expValue   = expectedValue(op, row.a, row.b);
        testTable[idx] = row;
    endtask

    task automatic buildImage(input testRowT row);
        logic [127:0] code;
        int           len;
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            prog[i]  = {i[7:4] ^ i[3:0], 4'hE};  // unused bytes decode as unknown opcodes
            image[i] = {4'h5, i[7:0]};
        end
        image[0] = row.a;
        image[1] = row.b;
        if (row.op == LDAC) begin
            image[row.a[`ADDR_WIDTH-1:0]] = row.b;
        end
        case (row.op)
            ADD:      code = 128'({LDIAC, 8'd0, MV_R_AC, LDIAC, 8'd1, ADD, STIR, 8'd2, ENDOP});
            SUB:      code = 128'({LDIAC, 8'd0, MV_RC_AC, LDIAC, 8'd1, SUB, STIR, 8'd2, ENDOP});
            MUL:      code = 128'({LDIAC, 8'd0, MV_R1_AC, LDIAC, 8'd1, MUL, STIR, 8'd2, ENDOP});
            JMPZ:     code = 128'({CLAC, JMPZ, 8'd8, LDIAC, 8'd0, STIR, 8'd2, ENDOP,
                                   LDIAC, 8'd1, STIR, 8'd2, ENDOP});
            JMPNZ:    code = 128'({INCAC, JMPNZ, 8'd8, LDIAC, 8'd0, STIR, 8'd2, ENDOP,
                                   LDIAC, 8'd1, STIR, 8'd2, ENDOP});
            LDAC:     code = 128'({LDIAC, 8'd0, LDAC, STIR, 8'd2, ENDOP});
            STR:      code = 128'({LDIAC, 8'd1, MV_R_AC, LDIAC, 8'd0, STR, ENDOP});
            MV_AC_RP: code = 128'({LDIAC, 8'd0, MV_RP_AC, MUL, MUL, MUL, MV_AC_RP,
                                   STIR, 8'd2, ENDOP});
            default:  code = 128'({LDIAC, 8'd0, INCAC, MV_RL_AC, CLAC, MV_AC_RL,
                                   STIR, 8'd2, ENDOP});
        endcase
        // no program opens with NOP, so the top nonzero byte is the first one
        len = 16;
        while (len > 0 && code[len * 8 - 1 -: 8] == 8'h00) begin
            len--;
        end
        for (int i = 0; i < len; i++) begin
            prog[i] = code[(len - i) * 8 - 1 -: 8];
        end
    endtask

    task automatic loadImage();
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            host = '{imemWe: 1'b1, dmemWe: 1'b0, addr: i[7:0], data: dataWordT'(prog[i])};
            stepCycle();
        end
        for (int i = 0; i < `MEM_DEPTH; i++) begin
            host = '{imemWe: 1'b0, dmemWe: 1'b1, addr: i[7:0], data: image[i]};
            stepCycle();
        end
        host = '0;
    endtask

    task automatic readWord(input logic [`ADDR_WIDTH-1:0] addr, output dataWordT value);
        host = '{imemWe: 1'b0, dmemWe: 1'b0, addr: addr, data: '0};
        stepCycle();  // port B registers the read on this edge
        value = hostRdata;
    endtask

    task automatic applyReset();
        reset = 1'b1;
        start = 1'b0;
        host  = '0;
        repeat (resetCycles) stepCycle();
        reset = 1'b0;
        stepCycle();
    endtask

    task automatic waitForDone(input int rowIdx);
        int cycles;
        cycles = 0;
        while (!done) begin
            if (cycles == doneTimeout) begin
                abortRun($sformatf("Timed out waiting for done in row %0d", rowIdx));
            end
            stepCycle();
            cycles++;
        end
    endtask

    initial begin
        testRowT  row;
        dataWordT got;
        clk   = 1'b0;
        reset = 1'b1;
        start = 1'b0;
        host  = '0;
        seed  = 32'h0484a0b0;
        setRow(0, ADD, 12'h123, 12'h456, 1'b0);
        setRow(1, ADD, '0, '0, 1'b1);
        setRow(2, SUB, 12'h005, 12'h003, 1'b0);  // borrows through zero
        setRow(3, SUB, '0, '0, 1'b1);
        setRow(4, MUL, 12'hFFF, 12'h002, 1'b0);  // product overflows 12 bits
        setRow(5, MUL, '0, '0, 1'b1);
        setRow(6, JMPZ, '0, '0, 1'b1);
        setRow(7, JMPNZ, '0, '0, 1'b1);
        setRow(8, LDAC, '0, '0, 1'b1);
        setRow(9, STR, '0, '0, 1'b1);
        setRow(10, MV_AC_RP, '0, '0, 1'b1);
        setRow(11, MV_AC_RL, '0, '0, 1'b1);
        setRow(12, MV_AC_RP, 12'hFFE, '0, 1'b0);  // RP wraps past zero
        for (int n = 0; n < numRows; n++) begin
            row = testTable[n];
            applyReset();
            checkFlags("after reset", 1'b1, 1'b0);
            buildImage(row);
            loadImage();
            start = 1'b1;
            stepCycle();
            start = 1'b0;
            checkFlags("after start", 1'b0, 1'b0);
            waitForDone(n);
            repeat (3) begin
                stepCycle();
                checkFlags("while done", 1'b0, 1'b1);
            end
            readWord(row.expAddr, got);
            checkWord($sformatf("row %0d op %02h dmem[%0d]", n, row.op, row.expAddr),
                      got, row.expValue);
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* flist.f */
+incdir+hdl
hdl/cpuPkg.sv
hdl/controlUnit.sv
hdl/dataPath.sv
hdl/dualPortRam.sv
hdl/processorTop.sv
sim/processor_assert.sv
sim/processorTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= processorTb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIMFLAGS  ?= -Wno-fatal
PASS_TEXT ?= SIMULATION PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) $(SIMFLAGS) -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
